// ==== all.f ====
+incdir+.
phys_pkg.sv
control_decode.sv
fix_divider.sv
velocity_stage.sv
position_stage.sv
physics_core.sv
tb_clock.sv
physics_core_tb.sv

// ==== control_decode.sv ====
`timescale 1ns/1ps
`include "phys_params.svh"

module control_decode (
	input  logic            clock,
	input  logic            reset,
	input  logic            frame_start,
	input  logic [31:0]     controller_in,
	input  logic [31:0]     knockback_in,
	input  phys_pkg::wall_t wall,
	input  logic            attack_in,
	input  logic            freeze_in,
	output logic            cmd_valid,
	output phys_pkg::fix_t  move_x,
	output phys_pkg::fix_t  move_y,
	output phys_pkg::fix_t  knock_x,
	output phys_pkg::fix_t  knock_y,
	output logic            grounded,
	output logic            jump_fire,
	output logic            attack,
	output logic            freeze
);
	import phys_pkg::*;

	joy_t joy_x;
	joy_t joy_y;
	logic signed [8:0] sjoy_x;
	logic signed [8:0] sjoy_y;
	logic pressed;
	logic on_ground;
	logic fire;
	logic jump_prev;  // Jump was held last frame
	logic jump_used;  // Jump spent since last grounded frame

	assign joy_x = controller_in[15:8];
	assign joy_y = controller_in[7:0];

	// Centre the bytes, range -112 to 143
	assign sjoy_x = {1'b0, joy_x} - 9'(`PHYS_JOY_CENTER);
	assign sjoy_y = {1'b0, joy_y} - 9'(`PHYS_JOY_CENTER);

	assign pressed = joy_y >= joy_t'(`PHYS_JUMP_MIN);
	assign on_ground = wall[1] | wall[4];  // Floor or platform

	// Rising press, and either grounded now or not yet spent in the air
	assign fire = pressed & ~jump_prev & (on_ground | ~jump_used) & ~attack_in & ~freeze_in;

	always_ff @(posedge clock) begin
		if (reset) begin
			cmd_valid <= 1'b0;
			jump_prev <= 1'b0;
			jump_used <= 1'b0;
		end else begin
			cmd_valid <= frame_start;
			if (frame_start && !freeze_in) begin  // Frozen frames keep jump state
				jump_prev <= pressed;
				if (on_ground)
					jump_used <= fire;  // Ground re-arms unless jumping off it
				else if (fire)
					jump_used <= 1'b1;
			end
		end
	end

	// Frame commands, held until the next frame
	always_ff @(posedge clock) begin
		if (frame_start) begin
			move_x    <= fix_t'(sjoy_x) <<< `PHYS_MOVE_SHIFT;
			move_y    <= fix_t'(sjoy_y) <<< `PHYS_MOVE_SHIFT;
			knock_x   <= fix_t'($signed(knockback_in[31:16])) <<< 16;
			knock_y   <= fix_t'($signed(knockback_in[15:0])) <<< 16;
			grounded  <= on_ground;
			jump_fire <= fire;
			attack    <= attack_in;
			freeze    <= freeze_in;
		end
	end

endmodule

// ==== fix_divider.sv ====
`timescale 1ns/1ps
`include "phys_params.svh"

module fix_divider (
	input  logic            clock,
	input  logic            reset,
	input  logic            start,
	input  phys_pkg::fix_t  dividend,
	input  phys_pkg::mass_t divisor,
	output logic            done,
	output phys_pkg::fix_t  quotient
);
	import phys_pkg::*;

	localparam int CNT_W = $clog2(`PHYS_FIX_W);

	div_state_t state;
	logic [CNT_W-1:0] count;
	logic [`PHYS_FIX_W-1:0] work;   // Dividend bits shift out, quotient bits in
	logic [`PHYS_MASS_W-1:0] rem;
	mass_t dvsr;
	logic negative;
	logic by_zero;
	logic [`PHYS_MASS_W:0] rem_shift;
	logic [`PHYS_MASS_W:0] rem_sub;
	logic q_bit;
	logic [`PHYS_FIX_W-1:0] q_next;

	assign rem_shift = {rem, work[`PHYS_FIX_W-1]};
	assign rem_sub = rem_shift - {1'b0, dvsr};
	assign q_bit = ~rem_sub[`PHYS_MASS_W];  // No borrow, divisor fits
	assign q_next = {work[`PHYS_FIX_W-2:0], q_bit};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= div_idle;
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				div_idle: if (start) begin
					state <= div_run;
					count <= '0;
				end
				div_run: begin
					count <= count + 1'b1;
					if (count == CNT_W'(`PHYS_FIX_W-1)) begin
						state <= div_idle;
						done  <= 1'b1;
					end
				end
				default: state <= div_idle;
			endcase
		end
	end

	// Magnitude datapath, one quotient bit per cycle
	always_ff @(posedge clock) begin
		if (state == div_idle && start) begin
			negative <= dividend[`PHYS_FIX_W-1];
			by_zero  <= (divisor == '0);
			work     <= dividend[`PHYS_FIX_W-1] ? -dividend : dividend;
			rem      <= '0;
			dvsr     <= divisor;
		end else if (state == div_run) begin
			work <= q_next;
			rem  <= q_bit ? rem_sub[`PHYS_MASS_W-1:0] : rem_shift[`PHYS_MASS_W-1:0];
			if (count == CNT_W'(`PHYS_FIX_W-1)) begin
				if (by_zero)
					quotient <= '0;
				else if (negative)
					quotient <= -fix_t'(q_next);  // Truncate toward zero
				else
					quotient <= fix_t'(q_next);
			end
		end
	end

endmodule

// ==== phys_params.svh ====
`ifndef PHYS_PARAMS_SVH
`define PHYS_PARAMS_SVH

// Fixed-point word layout
`define PHYS_FIX_W      48
`define PHYS_FRAC_W     32
`define PHYS_COORD_W    16
`define PHYS_MASS_W     32

// Joystick mapping
`define PHYS_JOY_CENTER 112
`define PHYS_MOVE_SHIFT 10
`define PHYS_JUMP_MIN   240   // Top of the y axis means jump

// Airborne velocity change per frame
`define PHYS_RAMP_STEP  4096

// Jump numerator, divided by mass
`define PHYS_JUMP_IMPULSE 48'h40000

`endif

// ==== phys_pkg.sv ====
`include "phys_params.svh"

package phys_pkg;

	// Position and velocity words
	typedef logic signed [`PHYS_FIX_W-1:0] fix_t;

	// Integer part of a position
	typedef logic [`PHYS_COORD_W-1:0] coord_t;

	typedef logic [7:0] joy_t;  // One joystick axis, 0 to 255

	// Bit 0 up, 1 down, 2 right, 3 left, 4 platform below
	typedef logic [4:0] wall_t;

	typedef logic [`PHYS_MASS_W-1:0] mass_t;  // Mass and gravity

	// Host handshake
	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_ack
	} step_state_t;

	typedef enum logic {
		div_idle,
		div_run
	} div_state_t;

endpackage

// ==== physics_core.sv ====
`timescale 1ns/1ps

module physics_core (
	input  logic            clock,
	input  logic            reset,
	input  logic            step_req,
	input  phys_pkg::mass_t mass_in,
	input  phys_pkg::mass_t gravity_in,
	input  logic [31:0]     start_position,
	input  logic [31:0]     controller_in,
	input  logic [31:0]     knockback_in,
	input  phys_pkg::wall_t wall,
	input  logic            attack_in,
	input  logic            freeze_in,
	output logic            step_ack,
	output logic [31:0]     position
);
	import phys_pkg::*;

	step_state_t state;
	logic frame_start;
	logic cmd_valid;
	fix_t move_x;
	fix_t move_y;
	fix_t knock_x;
	fix_t knock_y;
	logic grounded;
	logic jump_fire;
	logic attack;
	logic freeze;
	logic vel_done;
	fix_t vel_prev_x;
	fix_t vel_prev_y;
	logic hold_pos;
	logic pos_done;

	// Four-phase handshake, one frame in flight
	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= st_idle;
			frame_start <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			case (state)
				st_idle: if (step_req) begin
					state       <= st_busy;
					frame_start <= 1'b1;
				end
				st_busy: if (pos_done) state <= st_ack;
				st_ack: if (!step_req) state <= st_idle;  // Wait for request to drop
				default: state <= st_idle;
			endcase
		end
	end

	assign step_ack = (state == st_ack);

	control_decode u_decode (
		.clock         (clock),
		.reset         (reset),
		.frame_start   (frame_start),
		.controller_in (controller_in),
		.knockback_in  (knockback_in),
		.wall          (wall),
		.attack_in     (attack_in),
		.freeze_in     (freeze_in),
		.cmd_valid     (cmd_valid),
		.move_x        (move_x),
		.move_y        (move_y),
		.knock_x       (knock_x),
		.knock_y       (knock_y),
		.grounded      (grounded),
		.jump_fire     (jump_fire),
		.attack        (attack),
		.freeze        (freeze)
	);

	velocity_stage u_velocity (
		.clock      (clock),
		.reset      (reset),
		.cmd_valid  (cmd_valid),
		.move_x     (move_x),
		.move_y     (move_y),
		.knock_x    (knock_x),
		.knock_y    (knock_y),
		.grounded   (grounded),
		.jump_fire  (jump_fire),
		.attack     (attack),
		.freeze     (freeze),
		.mass_in    (mass_in),
		.gravity_in (gravity_in),
		.vel_done   (vel_done),
		.vel_x      (),             // Current velocity, debug only
		.vel_y      (),
		.vel_prev_x (vel_prev_x),
		.vel_prev_y (vel_prev_y),
		.hold_pos   (hold_pos)
	);

	position_stage u_position (
		.clock          (clock),
		.reset          (reset),
		.vel_done       (vel_done),
		.vel_prev_x     (vel_prev_x),
		.vel_prev_y     (vel_prev_y),
		.hold_pos       (hold_pos),
		.start_position (start_position),
		.pos_done       (pos_done),
		.position       (position)
	);

endmodule

// ==== physics_core_tb.sv ====
`timescale 1ns/1ps
`include "phys_params.svh"

module physics_core_tb;
	import phys_pkg::*;

	localparam int TOTAL_STEPS = 4 + 12 + 6 + 8 + 4 + 200;
	localparam int TIMEOUT_CYCLES = 120 * TOTAL_STEPS;
	localparam logic [31:0] START_POS = 32'h0040_0080;
	localparam logic [31:0] CTRL_IDLE = 32'h0000_7070;  // Both axes centred

	logic clock;
	logic reset;
	logic step_req;
	mass_t mass_in;
	mass_t gravity_in;
	logic [31:0] start_position;
	logic [31:0] controller_in;
	logic [31:0] knockback_in;
	wall_t wall;
	logic attack_in;
	logic freeze_in;
	logic step_ack;
	logic [31:0] position;

	fix_t m_pos_x;  // Reference model state
	fix_t m_pos_y;
	longint m_vx;
	longint m_vy;
	bit m_jprev;
	bit m_jused;

	logic [31:0] exp_position;
	fix_t exp_pos_x;
	fix_t exp_pos_y;
	string test_name;
	int value_errors = 0;
	int handshake_errors = 0;
	int unsigned cycle_count;
	logic ack_prev;
	logic req_prev;

	mass_t masses [4] = '{32'd1, 32'd6, 32'd0, 32'd250};
	wall_t jump_walls [8] = '{5'b00010, 5'b0, 5'b0, 5'b0, 5'b10000, 5'b0, 5'b0, 5'b0};
	joy_t jump_y [8] = '{8'd248, 8'd248, 8'd112, 8'd248, 8'd112, 8'd248, 8'd112, 8'd248};
	int unsigned seed_val;
	logic [31:0] r_ctrl;
	logic [31:0] r_kb;
	wall_t r_wall;
	logic r_atk;
	logic r_frz;
	mass_t r_mass;
	mass_t r_grav;

	tb_clock clk_gen (.clock(clock));

	physics_core uut (
		.clock          (clock),
		.reset          (reset),
		.step_req       (step_req),
		.mass_in        (mass_in),
		.gravity_in     (gravity_in),
		.start_position (start_position),
		.controller_in  (controller_in),
		.knockback_in   (knockback_in),
		.wall           (wall),
		.attack_in      (attack_in),
		.freeze_in      (freeze_in),
		.step_ack       (step_ack),
		.position       (position)
	);

	function automatic longint div_toward_zero(input longint num, input mass_t mass);
		longint den;
		den = mass;
		if (den == 0)
			div_toward_zero = 0;  // Zero mass gives no motion
		else
			div_toward_zero = num / den;
	endfunction

	function automatic longint ramp_toward(input longint cur, input longint tgt);
		if (tgt - cur > `PHYS_RAMP_STEP)
			ramp_toward = cur + `PHYS_RAMP_STEP;
		else if (tgt - cur < -`PHYS_RAMP_STEP)
			ramp_toward = cur - `PHYS_RAMP_STEP;
		else
			ramp_toward = tgt;
	endfunction

	// One frame of the frame rules, returns the expected integer position
	function automatic logic [31:0] phys_model_step(input logic [31:0] ctrl,
			input logic [31:0] kb, input wall_t wl, input logic atk, input logic frz,
			input mass_t mass, input mass_t grav);
		longint mv_x;
		longint mv_y;
		longint num_y;
		longint qx;
		longint qy;
		logic signed [15:0] kx;
		logic signed [15:0] ky;
		bit pressed;
		bit ground;
		bit fire;
		mv_x = (longint'(ctrl[15:8]) - `PHYS_JOY_CENTER) <<< `PHYS_MOVE_SHIFT;
		mv_y = (longint'(ctrl[7:0]) - `PHYS_JOY_CENTER) <<< `PHYS_MOVE_SHIFT;
		pressed = ctrl[7:0] >= `PHYS_JUMP_MIN;
		ground = wl[1] | wl[4];
		if (!frz) begin
			fire = pressed && !m_jprev && (ground || !m_jused) && !atk;
			m_jprev = pressed;
			if (ground)
				m_jused = fire;
			else if (fire)
				m_jused = 1'b1;
			if (atk) begin
				kx = kb[31:16];
				ky = kb[15:0];
				m_vx = longint'(kx) * 65536;
				m_vy = longint'(ky) * 65536;
			end else begin
				m_pos_x = m_pos_x + fix_t'(m_vx);  // Old velocity moves the player
				m_pos_y = m_pos_y + fix_t'(m_vy);
				if (fire)
					num_y = longint'(`PHYS_JUMP_IMPULSE);
				else
					num_y = mv_y;
				qx = div_toward_zero(mv_x, mass);
				qy = div_toward_zero(num_y, mass);
				if (ground) begin
					m_vx = qx;
					m_vy = fire ? qy : 0;
				end else begin
					m_vx = ramp_toward(m_vx, qx);
					m_vy = fire ? qy : ramp_toward(m_vy, qy - longint'(grav));
				end
			end
		end
		phys_model_step = {m_pos_x[`PHYS_FIX_W-1 -: 16], m_pos_y[`PHYS_FIX_W-1 -: 16]};
	endfunction

	// One four-phase step, optionally holding the request after the ack
	task automatic run_step(input string name, input logic [31:0] ctrl, input logic [31:0] kb,
			input wall_t wl, input logic atk, input logic frz, input mass_t mass,
			input mass_t grav, input int hold_cycles);
		controller_in = ctrl;
		knockback_in = kb;
		wall = wl;
		attack_in = atk;
		freeze_in = frz;
		mass_in = mass;
		gravity_in = grav;
		test_name = name;
		exp_position = phys_model_step(ctrl, kb, wl, atk, frz, mass, grav);
		exp_pos_x = m_pos_x;
		exp_pos_y = m_pos_y;
		step_req = 1'b1;
		@(posedge clock);
		#1;
		while (!step_ack) begin
			@(posedge clock);
			#1;
		end
		repeat (hold_cycles) begin
			@(posedge clock);
			#1;
			assert (step_ack && position == exp_position) else begin
				handshake_errors++;
				$display("Held request in %s dropped step_ack or started a new frame", name);
			end
		end
		step_req = 1'b0;
		@(posedge clock);
		#1;
		while (step_ack) begin
			@(posedge clock);
			#1;
		end
	endtask

	// Compare on every rising ack, watch the handshake every cycle
	always @(posedge clock) begin
		if (reset) begin
			ack_prev <= 1'b0;
			req_prev <= 1'b0;
		end else begin
			ack_prev <= step_ack;
			req_prev <= step_req;
			if (step_ack && !ack_prev) begin
				assert (position == exp_position) else begin
					value_errors++;
					$display("Error: %s position expected %h actual %h",
						test_name, exp_position, position);
				end
				assert (uut.u_position.pos_x == exp_pos_x) else begin
					value_errors++;
					$display("Error: %s pos_x expected %h actual %h",
						test_name, exp_pos_x, uut.u_position.pos_x);
				end
				assert (uut.u_position.pos_y == exp_pos_y) else begin
					value_errors++;
					$display("Error: %s pos_y expected %h actual %h",
						test_name, exp_pos_y, uut.u_position.pos_y);
				end
			end
			assert (step_req || req_prev || !step_ack) else begin
				handshake_errors++;
				$display("The handshake broke: step_ack stayed high after step_req fell");
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed_val = $urandom(96);
		reset = 1'b1;
		step_req = 1'b0;
		mass_in = '0;
		gravity_in = '0;
		start_position = START_POS;
		controller_in = CTRL_IDLE;
		knockback_in = '0;
		wall = '0;
		attack_in = 1'b0;
		freeze_in = 1'b0;
		m_pos_x = {START_POS[31:16], 32'h0};
		m_pos_y = {START_POS[15:0], 32'h0};
		m_vx = 0;
		m_vy = 0;
		m_jprev = 1'b0;
		m_jused = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		repeat (4) begin  // Jump held and wall down, but frozen
			run_step("freeze", 32'h0000_C8F8, 32'h1234_5678, 5'b00010, 1'b0, 1'b1,
				32'd2, 32'h100, 0);
			assert (position == START_POS) else begin
				value_errors++;
				$display("Error: freeze position expected %h actual %h", START_POS, position);
			end
		end

		foreach (masses[m])
			repeat (3)
				run_step("grounded_move", 32'h0000_C870, 32'h0, 5'b00010, 1'b0, 1'b0,
					masses[m], 32'h0, 0);

		repeat (6)
			run_step("airborne_fall", 32'h0000_1E70, 32'h0, 5'b00000, 1'b0, 1'b0,
				32'd3, 32'h0100_0000, 0);

		foreach (jump_walls[j])
			run_step("jump", {16'h0, 8'd112, jump_y[j]}, 32'h0, jump_walls[j], 1'b0, 1'b0,
				32'd4, 32'h0010_0000, 0);

		run_step("attack", CTRL_IDLE, 32'h1234_E000, 5'b00010, 1'b1, 1'b0, 32'd5, 32'h0, 0);
		run_step("knockback", CTRL_IDLE, 32'h0, 5'b00010, 1'b0, 1'b0, 32'd5, 32'h0, 0);
		run_step("held_request", CTRL_IDLE, 32'h0, 5'b00000, 1'b0, 1'b0, 32'd5, 32'h400, 10);
		run_step("attack_air", CTRL_IDLE, 32'h8000_7FFF, 5'b00000, 1'b1, 1'b0, 32'd5, 32'h0, 0);

		for (int i = 0; i < 200; i++) begin
			r_ctrl = $urandom;
			if ($urandom % 3 == 0)
				r_ctrl[7:0] = 8'hF8;  // Press jump often
			r_kb = $urandom;
			r_wall = wall_t'($urandom);
			r_atk = ($urandom % 8) == 0;
			r_frz = ($urandom % 8) == 0;
			r_mass = ($urandom % 5 == 0) ? 32'd0 : $urandom_range(1, 400);
			r_grav = $urandom_range(0, 32'h0100_0000);
			run_step("random", r_ctrl, r_kb, r_wall, r_atk, r_frz, r_mass, r_grav, 0);
		end

		$display("Summary: %0d value errors, %0d handshake errors",
			value_errors, handshake_errors);
		if (value_errors == 0 && handshake_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== position_stage.sv ====
`timescale 1ns/1ps
`include "phys_params.svh"

module position_stage (
	input  logic           clock,
	input  logic           reset,
	input  logic           vel_done,
	input  phys_pkg::fix_t vel_prev_x,
	input  phys_pkg::fix_t vel_prev_y,
	input  logic           hold_pos,
	input  logic [31:0]    start_position,
	output logic           pos_done,
	output logic [31:0]    position
);
	import phys_pkg::*;

	fix_t pos_x;
	fix_t pos_y;
	coord_t start_x;
	coord_t start_y;

	assign start_x = start_position[31:16];
	assign start_y = start_position[15:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			// Whole-pixel start, fraction cleared
			pos_x    <= {start_x, `PHYS_FRAC_W'(0)};
			pos_y    <= {start_y, `PHYS_FRAC_W'(0)};
			pos_done <= 1'b0;
		end else begin
			pos_done <= vel_done;
			if (vel_done && !hold_pos) begin
				pos_x <= pos_x + vel_prev_x;
				pos_y <= pos_y + vel_prev_y;
			end
		end
	end

	// Integer parts only
	assign position = {pos_x[`PHYS_FIX_W-1 -: `PHYS_COORD_W],
		pos_y[`PHYS_FIX_W-1 -: `PHYS_COORD_W]};

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

// Free-running testbench clock
module tb_clock #(
	parameter real PERIOD = 4.0
) (
	output logic clock
);

	initial clock = 1'b0;

	always #(PERIOD / 2.0) clock = ~clock;

endmodule

// ==== velocity_stage.sv ====
`timescale 1ns/1ps
`include "phys_params.svh"

module velocity_stage (
	input  logic            clock,
	input  logic            reset,
	input  logic            cmd_valid,
	input  phys_pkg::fix_t  move_x,
	input  phys_pkg::fix_t  move_y,
	input  phys_pkg::fix_t  knock_x,
	input  phys_pkg::fix_t  knock_y,
	input  logic            grounded,
	input  logic            jump_fire,
	input  logic            attack,
	input  logic            freeze,
	input  phys_pkg::mass_t mass_in,
	input  phys_pkg::mass_t gravity_in,
	output logic            vel_done,
	output phys_pkg::fix_t  vel_x,
	output phys_pkg::fix_t  vel_y,
	output phys_pkg::fix_t  vel_prev_x,
	output phys_pkg::fix_t  vel_prev_y,
	output logic            hold_pos
);
	import phys_pkg::*;

	fix_t num_y;
	fix_t quot_x;
	fix_t quot_y;
	fix_t gravity_fix;
	fix_t target_y_air;
	logic done_x;
	logic done_y;
	logic both_done;

	// Step toward the target, snap once within one step
	function automatic fix_t ramp(input fix_t cur, input fix_t tgt);
		fix_t diff;
		diff = tgt - cur;
		if (diff > fix_t'(`PHYS_RAMP_STEP))
			ramp = cur + fix_t'(`PHYS_RAMP_STEP);
		else if (diff < -fix_t'(`PHYS_RAMP_STEP))
			ramp = cur - fix_t'(`PHYS_RAMP_STEP);
		else
			ramp = tgt;
	endfunction

	assign num_y = jump_fire ? fix_t'(`PHYS_JUMP_IMPULSE) : move_y;
	assign gravity_fix = fix_t'(gravity_in);  // Unsigned, zero extended
	assign target_y_air = quot_y - gravity_fix;

	// Both dividers share start and latency, so done pulses coincide
	assign both_done = done_x & done_y;

	fix_divider div_x (
		.clock    (clock),
		.reset    (reset),
		.start    (cmd_valid),
		.dividend (move_x),
		.divisor  (mass_in),
		.done     (done_x),
		.quotient (quot_x)
	);

	fix_divider div_y (
		.clock    (clock),
		.reset    (reset),
		.start    (cmd_valid),
		.dividend (num_y),
		.divisor  (mass_in),
		.done     (done_y),
		.quotient (quot_y)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			vel_done   <= 1'b0;
			hold_pos   <= 1'b0;
			vel_x      <= '0;
			vel_y      <= '0;
			vel_prev_x <= '0;
			vel_prev_y <= '0;
		end else begin
			vel_done <= both_done;
			if (both_done) begin
				vel_prev_x <= vel_x;  // Position integrates the old velocity
				vel_prev_y <= vel_y;
				hold_pos   <= attack | freeze;
				if (!freeze) begin
					if (attack) begin
						vel_x <= knock_x;
						vel_y <= knock_y;
					end else if (grounded) begin
						vel_x <= quot_x;
						vel_y <= jump_fire ? quot_y : '0;
					end else begin
						// Airborne
						vel_x <= ramp(vel_x, quot_x);
						vel_y <= jump_fire ? quot_y : ramp(vel_y, target_y_air);
					end
				end
			end
		end
	end

endmodule
